/* project.f */
+incdir+verilog
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/ecl_issue.sv
verilog/ecl_bypass.sv
verilog/ecl_writeback.sv
verilog/exu_ecl.sv
tests/ecl_asserts.sv
tests/tb_exu_ecl.sv

/* run.sh */
#!/bin/sh
# build and run the exu_ecl testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_exu_ecl
status=$?
if [ $status -ne 0 ]; then
   echo "build failed with status $status"
   exit 1
fi

./obj_dir/Vtb_exu_ecl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
   exit 1
fi
exit 0

/* tests/tb_exu_ecl.sv */
`timescale 1ns/1ps

module tb_exu_ecl;

   localparam int          N_RANDOM    = 150;
   localparam int          TOTAL_INSTR = N_RANDOM + 40;
   localparam int          LIMIT       = TOTAL_INSTR * 8 + 16;
   localparam logic [31:0] SEED        = 32'h6ef18372;

   typedef struct packed {
      isa_pkg::unit_t    kind;
      isa_pkg::reg_idx_t rd;
      isa_pkg::reg_idx_t rj;
      isa_pkg::reg_idx_t rk;
      isa_pkg::word_t    imm;
      isa_pkg::word_t    pc;
      logic              use_imm;
      logic              pc_a;
      logic              sub;
      logic              taken;
      logic              link;
   } instr_t;

   typedef struct packed {
      isa_pkg::reg_idx_t rd;
      isa_pkg::word_t    data;
      logic [31:0]       cyc;
      logic              timed;
      logic              is_load;
   } exp_t;

   logic                clk;
   logic                reset;
   pipe_pkg::issue_t    issue;
   isa_pkg::word_t      rs1_data;
   isa_pkg::word_t      rs2_data;
   isa_pkg::word_t      alu_res;
   pipe_pkg::lsu_resp_t lsu_resp;
   pipe_pkg::bru_resp_t bru_resp;
   isa_pkg::reg_idx_t   rs1_idx;
   isa_pkg::reg_idx_t   rs2_idx;
   pipe_pkg::alu_req_t  alu_req;
   pipe_pkg::lsu_req_t  lsu_req;
   pipe_pkg::bru_req_t  bru_req;
   logic                br_taken;
   isa_pkg::word_t      br_pc;
   logic                stall_req;
   pipe_pkg::wb_t       wb;

   isa_pkg::word_t rf [32];
   isa_pkg::word_t shadow [32];
   exp_t           exp_q [$];
   int             cycle;
   int             errors;
   int             tests_run;
   int             tests_failed;
   int             test_start_err;
   isa_pkg::word_t next_pc;
   isa_pkg::word_t stim_lfsr;
   isa_pkg::word_t delay_lfsr;

   // branch outcome, decode side and execute side
   logic           br_d_taken;
   logic           br_d_link_wen;
   isa_pkg::word_t br_d_link;
   logic           br_e_taken;
   logic           br_e_link_wen;
   isa_pkg::word_t br_e_link;

   // last presented instruction, if it was a taken branch
   logic           last_br_taken;
   isa_pkg::word_t last_br_target;

   // lsu model state
   logic              ld_busy;
   int                ld_cnt;
   isa_pkg::word_t    ld_addr;
   isa_pkg::reg_idx_t ld_rd;
   logic              ld_wen;
   int                ld_done_cyc;

   exu_ecl u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////
   // helpers
   ////////////////////

   function automatic isa_pkg::word_t lfsr_next(input isa_pkg::word_t s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   // one lfsr step per bit taken
   function automatic isa_pkg::word_t take_bits(inout isa_pkg::word_t s, input int n);
      isa_pkg::word_t v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         s = lfsr_next(s);
         v = {v[30:0], s[0]};
      end
      return v;
   endfunction

   // load data as a function of the full address
   function automatic isa_pkg::word_t mem_word(input isa_pkg::word_t addr);
      return (addr * 32'h9e3779b1) ^ 32'hc3a50f1e;
   endfunction

   function automatic logic writes_rf(input instr_t ins);
      return (ins.kind != isa_pkg::UNIT_BRU) || ins.link;
   endfunction

   // expected write value from program-order state
   function automatic isa_pkg::word_t ref_result(input instr_t ins);
      isa_pkg::word_t a;
      isa_pkg::word_t b;
      a = ins.pc_a ? ins.pc : shadow[ins.rj];
      b = ins.use_imm ? ins.imm : shadow[ins.rk];
      case (ins.kind)
         // address is operand a plus the immediate
         isa_pkg::UNIT_LSU: return mem_word(a + ins.imm);
         isa_pkg::UNIT_BRU: return ins.pc + 32'd4;
         default:           return ins.sub ? a - b : a + b;
      endcase
   endfunction

   function automatic instr_t make_inst(input isa_pkg::unit_t kind, input int rd, input int rj,
                                        input int rk, input isa_pkg::word_t imm,
                                        input logic [4:0] flags);
      instr_t ins;
      ins.kind    = kind;
      ins.rd      = rd[4:0];
      ins.rj      = rj[4:0];
      ins.rk      = rk[4:0];
      ins.imm     = imm;
      ins.pc      = '0;
      ins.use_imm = flags[4];
      ins.pc_a    = flags[3];
      ins.sub     = flags[2];
      ins.taken   = flags[1];
      ins.link    = flags[0];
      return ins;
   endfunction

   ////////////////////
   // stimulus
   ////////////////////

   task automatic send_inst(input instr_t ins, input logic timed);
      exp_t e;
      logic killed;
      @(negedge clk);
      while (stall_req) begin
         issue.valid = 1'b0;
         @(negedge clk);
      end
      ins.pc  = next_pc;
      next_pc = next_pc + 32'd4;
      // a taken branch presented last cycle is now in execute
      killed  = issue.valid & last_br_taken;
      assert (br_taken == killed) else begin
         $display("Error: %0t: br_taken = %0b, expected %0b", $time, br_taken, killed);
         errors++;
      end
      if (killed) begin
         assert (br_pc == last_br_target) else begin
            $display("Error: %0t: br_pc = %h, expected %h", $time, br_pc, last_br_target);
            errors++;
         end
      end
      issue.valid          = 1'b1;
      issue.inst           = {17'b0, ins.rk, ins.rj, ins.rd};
      issue.pc             = ins.pc;
      issue.op.unit        = ins.kind;
      issue.op.alu_op      = ins.sub ? 4'd1 : 4'd0;
      issue.op.lsu_op      = '0;
      issue.op.bru_op      = '0;
      issue.op.imm_b       = ins.use_imm;
      issue.op.pc_a        = ins.pc_a;
      issue.op.rd_as_rj    = 1'b0;
      issue.op.rd_read     = 1'b0;
      issue.op.double_read = 1'b0;
      issue.rf_wen         = ins.kind != isa_pkg::UNIT_BRU;
      issue.rf_target      = ins.rd;
      issue.imm            = ins.imm;
      issue.br_offs        = 32'h40;
      br_d_taken    = ins.taken;
      br_d_link_wen = ins.link;
      br_d_link     = ins.pc + 32'd4;
      // branch target is the branch pc plus its offset
      last_br_taken  = ~killed & (ins.kind == isa_pkg::UNIT_BRU) & ins.taken;
      last_br_target = ins.pc + 32'h40;
      if (!killed && writes_rf(ins)) begin
         e.rd      = ins.rd;
         e.data    = ref_result(ins);
         e.cyc     = cycle + 3;
         e.timed   = timed;
         e.is_load = ins.kind == isa_pkg::UNIT_LSU;
         exp_q.push_back(e);
         if (ins.rd != 0) begin
            shadow[ins.rd] = e.data;
         end
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge clk);
         issue.valid = 1'b0;
      end
   endtask

   task automatic drain_pipe();
      idle_cycles(1);
      while (exp_q.size() != 0 || stall_req) begin
         @(negedge clk);
      end
      idle_cycles(2);
   endtask

   task automatic close_test(input string name);
      tests_run++;
      if (errors != test_start_err) begin
         tests_failed++;
      end
      $display("test %s: %s", name, (errors == test_start_err) ? "ok" : "failed");
      test_start_err = errors;
   endtask

   ////////////////////
   // unit models
   ////////////////////

   always_comb begin
      rs1_data = (rs1_idx == 0) ? '0 : (wb.wen && wb.rd == rs1_idx) ? wb.data : rf[rs1_idx];
      rs2_data = (rs2_idx == 0) ? '0 : (wb.wen && wb.rd == rs2_idx) ? wb.data : rf[rs2_idx];
      alu_res  = (alu_req.op == 4'd1) ? alu_req.a - alu_req.b : alu_req.a + alu_req.b;
      bru_resp.taken   = bru_req.valid & br_e_taken;
      bru_resp.brpc    = bru_req.pc + bru_req.offset;
      bru_resp.link_pc = br_e_link;
      bru_resp.wen     = br_e_link_wen;
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (wb.wen && wb.rd != 0) begin
         rf[wb.rd] <= wb.data;
      end
      if (issue.valid) begin
         br_e_taken    <= br_d_taken;
         br_e_link_wen <= br_d_link_wen;
         br_e_link     <= br_d_link;
      end
   end

   // lsu with a random 2 to 5 cycle latency
   always @(negedge clk) begin
      isa_pkg::word_t r;
      if (!reset) begin
         if (lsu_resp.finish) begin
            assert (!stall_req) else begin
               $display("Error: %0t: stall_req still high after finish", $time);
               errors++;
            end
            lsu_resp.finish = 1'b0;
         end
         if (ld_busy) begin
            assert (stall_req) else begin
               $display("Error: %0t: stall_req low while load outstanding", $time);
               errors++;
            end
            ld_cnt = ld_cnt - 1;
            if (ld_cnt == 0) begin
               ld_busy         = 1'b0;
               lsu_resp.finish = 1'b1;
               lsu_resp.rdata  = mem_word(ld_addr);
               lsu_resp.rd     = ld_rd;
               lsu_resp.wen    = ld_wen;
               // load result due on wb the cycle after finish
               ld_done_cyc     = cycle + 1;
            end
         end
         if (lsu_req.valid) begin
            assert (stall_req) else begin
               $display("Error: %0t: stall_req low in lsu issue cycle", $time);
               errors++;
            end
            r       = take_bits(delay_lfsr, 2);
            ld_cnt  = 2 + int'(r[1:0]);
            ld_busy = 1'b1;
            ld_addr = lsu_req.base + lsu_req.offset;
            ld_rd   = lsu_req.rd;
            ld_wen  = lsu_req.wen;
         end
      end
   end

   ////////////////////
   // comparison
   ////////////////////

   always @(negedge clk) begin
      exp_t e;
      if (!reset && wb.wen) begin
         if (exp_q.size() == 0) begin
            $display("register write r%0d with no write expected at %0t", wb.rd, $time);
            errors++;
         end else begin
            e = exp_q.pop_front();
            assert (wb.rd == e.rd && wb.data == e.data) else begin
               $display("Error: %0t: wb r%0d = %h, expected r%0d = %h",
                        $time, wb.rd, wb.data, e.rd, e.data);
               errors++;
            end
            assert (!e.timed || cycle == int'(e.cyc)) else begin
               $display("Error: %0t: write at cycle %0d, expected %0d", $time, cycle, e.cyc);
               errors++;
            end
            assert (!e.is_load || cycle == ld_done_cyc) else begin
               $display("Error: %0t: load write at cycle %0d, expected %0d",
                        $time, cycle, ld_done_cyc);
               errors++;
            end
         end
      end
   end

   always @(posedge clk) begin
      if (cycle > LIMIT) begin
         $display("timeout: run exceeded %0d cycles", LIMIT);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   ////////////////////
   // test sequence
   ////////////////////

   initial begin
      instr_t         ins;
      isa_pkg::word_t r;
      isa_pkg::unit_t unit_sel;
      isa_pkg::word_t rd_r;
      isa_pkg::word_t rj_r;
      isa_pkg::word_t rk_r;
      isa_pkg::word_t imm_r;
      reset      = 1'b1;
      issue      = '0;
      lsu_resp   = '0;
      cycle      = 0;
      errors     = 0;
      tests_run  = 0;
      tests_failed   = 0;
      test_start_err = 0;
      next_pc    = 32'h1c000000;
      stim_lfsr  = SEED;
      delay_lfsr = SEED;
      br_d_taken = 1'b0;
      br_d_link_wen = 1'b0;
      br_d_link  = '0;
      br_e_taken = 1'b0;
      br_e_link_wen = 1'b0;
      br_e_link  = '0;
      last_br_taken  = 1'b0;
      last_br_target = '0;
      ld_busy    = 1'b0;
      ld_cnt     = 0;
      ld_addr    = '0;
      ld_rd      = '0;
      ld_wen     = 1'b0;
      ld_done_cyc = 0;
      for (int i = 0; i < 32; i++) begin
         rf[i]     = '0;
         shadow[i] = '0;
      end
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      assert (!lsu_req.valid && !bru_req.valid && !wb.wen && !stall_req && !br_taken) else begin
         $display("Error: %0t: outputs active after reset", $time);
         errors++;
      end
      close_test("reset");

      send_inst(make_inst(isa_pkg::UNIT_ALU, 1, 0, 0, 32'h1234, 5'b10000), 1'b1);
      drain_pipe();
      send_inst(make_inst(isa_pkg::UNIT_ALU, 2, 1, 0, 32'h5, 5'b10000), 1'b1);
      drain_pipe();
      send_inst(make_inst(isa_pkg::UNIT_ALU, 3, 1, 2, 32'h0, 5'b00100), 1'b1);
      drain_pipe();
      close_test("alu_timing");

      for (int s = 1; s <= 3; s++) begin
         send_inst(make_inst(isa_pkg::UNIT_ALU, 4, 1, 0, s, 5'b10000), 1'b0);
         idle_cycles(s - 1);
         send_inst(make_inst(isa_pkg::UNIT_ALU, 5, 4, 4, 32'h0, 5'b00000), 1'b0);
         idle_cycles(s - 1);
         send_inst(make_inst(isa_pkg::UNIT_ALU, 4, 5, 1, 32'h0, 5'b00100), 1'b0);
         send_inst(make_inst(isa_pkg::UNIT_ALU, 6, 4, 0, 32'h20, 5'b11000), 1'b0);
         send_inst(make_inst(isa_pkg::UNIT_ALU, 7, 6, 4, 32'h7, 5'b10000), 1'b0);
      end
      drain_pipe();
      close_test("forwarding");

      send_inst(make_inst(isa_pkg::UNIT_LSU, 8, 1, 0, 32'h40, 5'b00000), 1'b0);
      send_inst(make_inst(isa_pkg::UNIT_ALU, 9, 8, 8, 32'h0, 5'b00000), 1'b0);
      send_inst(make_inst(isa_pkg::UNIT_LSU, 10, 9, 0, 32'h8, 5'b00000), 1'b0);
      send_inst(make_inst(isa_pkg::UNIT_LSU, 11, 10, 0, 32'h4, 5'b00000), 1'b0);
      drain_pipe();
      close_test("load");

      // r13 sits in decode under the taken branch
      send_inst(make_inst(isa_pkg::UNIT_BRU, 12, 1, 2, 32'h0, 5'b00011), 1'b0);
      send_inst(make_inst(isa_pkg::UNIT_ALU, 13, 0, 0, 32'h99, 5'b10000), 1'b0);
      send_inst(make_inst(isa_pkg::UNIT_ALU, 14, 12, 0, 32'h1, 5'b10000), 1'b0);
      send_inst(make_inst(isa_pkg::UNIT_BRU, 0, 1, 2, 32'h0, 5'b00000), 1'b0);
      send_inst(make_inst(isa_pkg::UNIT_ALU, 15, 14, 12, 32'h0, 5'b00000), 1'b0);
      drain_pipe();
      close_test("branch");

      for (int i = 0; i < N_RANDOM; i++) begin
         r = take_bits(stim_lfsr, 2);
         case (r[1:0])
            2'd1:    unit_sel = isa_pkg::UNIT_LSU;
            2'd2:    unit_sel = isa_pkg::UNIT_BRU;
            default: unit_sel = isa_pkg::UNIT_ALU;
         endcase
         rd_r  = take_bits(stim_lfsr, 3);
         rj_r  = take_bits(stim_lfsr, 3);
         rk_r  = take_bits(stim_lfsr, 3);
         imm_r = take_bits(stim_lfsr, 8);
         r     = take_bits(stim_lfsr, 5);
         ins = make_inst(unit_sel, int'(rd_r), int'(rj_r), int'(rk_r), imm_r, r[4:0]);
         send_inst(ins, 1'b0);
         r = take_bits(stim_lfsr, 2);
         if (r[1:0] == 2'd0) begin
            idle_cycles(1);
         end
      end
      drain_pipe();
      close_test("random_mix");

      $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* tests/ecl_asserts.sv */
`timescale 1ns/1ps

module ecl_asserts (
   input logic                clk,
   input logic                reset,
   input pipe_pkg::issue_t    issue,
   input logic                stall_req,
   input pipe_pkg::lsu_req_t  lsu_req,
   input pipe_pkg::lsu_resp_t lsu_resp,
   input pipe_pkg::bru_req_t  bru_req,
   input pipe_pkg::wb_t       wb
);

   // ifu must hold off while stalled
   a_no_valid_in_stall: assert property (@(posedge clk) disable iff (reset)
      issue.valid |-> !stall_req) else $error("issue valid during stall_req");

   ////////////////////
   // stall window
   ////////////////////

   a_stall_held: assert property (@(posedge clk) disable iff (reset)
      (stall_req && !lsu_resp.finish) |=> stall_req) else $error("stall_req dropped early");

   a_stall_release: assert property (@(posedge clk) disable iff (reset)
      lsu_resp.finish |=> !stall_req) else $error("stall_req held after finish");

   // everything quiet out of reset
   a_reset_quiet: assert property (@(posedge clk)
      reset |=> (!lsu_req.valid && !bru_req.valid && !wb.wen && !stall_req))
      else $error("outputs active after reset");

endmodule

bind exu_ecl ecl_asserts u_asserts (.*);

/* verilog/exu_ecl.sv */
`timescale 1ns/1ps

module exu_ecl (
   input  logic                clk,
   input  logic                reset,
   input  pipe_pkg::issue_t    issue,
   input  isa_pkg::word_t      rs1_data,
   input  isa_pkg::word_t      rs2_data,
   input  isa_pkg::word_t      alu_res,
   input  pipe_pkg::lsu_resp_t lsu_resp,
   input  pipe_pkg::bru_resp_t bru_resp,
   output isa_pkg::reg_idx_t   rs1_idx,
   output isa_pkg::reg_idx_t   rs2_idx,
   output pipe_pkg::alu_req_t  alu_req,
   output pipe_pkg::lsu_req_t  lsu_req,
   output pipe_pkg::bru_req_t  bru_req,
   output logic                br_taken,
   output isa_pkg::word_t      br_pc,
   output logic                stall_req,
   output pipe_pkg::wb_t       wb
);

   // execute-stage operands before and after forwarding
   isa_pkg::word_t    opa_e;
   isa_pkg::word_t    opb_e;
   isa_pkg::word_t    opa_fwd;
   isa_pkg::word_t    opb_fwd;
   isa_pkg::reg_idx_t rs1_e;
   isa_pkg::reg_idx_t rs2_e;
   logic              a_is_pc_e;
   logic              b_is_other_e;

   pipe_pkg::ex_ctl_t ex_ctl;
   isa_pkg::word_t    bru_link;
   logic              bru_link_wen;
   pipe_pkg::wb_t     wb_m;

   ecl_issue u_issue (
      .clk          (clk),
      .reset        (reset),
      .issue        (issue),
      .rs1_data     (rs1_data),
      .rs2_data     (rs2_data),
      .bru_resp     (bru_resp),
      .lsu_finish   (lsu_resp.finish),
      .opa_fwd      (opa_fwd),
      .opb_fwd      (opb_fwd),
      .rs1_idx      (rs1_idx),
      .rs2_idx      (rs2_idx),
      .opa_e        (opa_e),
      .opb_e        (opb_e),
      .rs1_e        (rs1_e),
      .rs2_e        (rs2_e),
      .a_is_pc_e    (a_is_pc_e),
      .b_is_other_e (b_is_other_e),
      .ex_ctl       (ex_ctl),
      .alu_req      (alu_req),
      .lsu_req      (lsu_req),
      .bru_req      (bru_req),
      .br_taken     (br_taken),
      .br_pc        (br_pc),
      .stall_req    (stall_req),
      .bru_link     (bru_link),
      .bru_link_wen (bru_link_wen)
   );

   // forwarding from memory and write-back
   ecl_bypass u_byp_rs1 (
      .rs_e      (rs1_e),
      .use_other (a_is_pc_e),
      .op_e      (opa_e),
      .wb_m      (wb_m),
      .wb_w      (wb),
      .op_fwd    (opa_fwd)
   );

   ecl_bypass u_byp_rs2 (
      .rs_e      (rs2_e),
      .use_other (b_is_other_e),
      .op_e      (opb_e),
      .wb_m      (wb_m),
      .wb_w      (wb),
      .op_fwd    (opb_fwd)
   );

   ecl_writeback u_wb (
      .clk          (clk),
      .reset        (reset),
      .ex_ctl       (ex_ctl),
      .alu_res      (alu_res),
      .bru_link     (bru_link),
      .bru_link_wen (bru_link_wen),
      .lsu_resp     (lsu_resp),
      .wb_m         (wb_m),
      .wb           (wb)
   );

endmodule

/* verilog/ecl_writeback.sv */
`timescale 1ns/1ps

module ecl_writeback (
   input  logic                clk,
   input  logic                reset,
   input  pipe_pkg::ex_ctl_t   ex_ctl,
   input  isa_pkg::word_t      alu_res,
   input  isa_pkg::word_t      bru_link,
   input  logic                bru_link_wen,
   input  pipe_pkg::lsu_resp_t lsu_resp,
   output pipe_pkg::wb_t       wb_m,
   output pipe_pkg::wb_t       wb
);

   logic              alu_wen_m;
   logic              link_wen_m;
   isa_pkg::reg_idx_t target_m;
   isa_pkg::word_t    alu_res_m;
   isa_pkg::word_t    link_m;
   logic              lsu_wen_m;

   ////////////////////
   // execute to memory
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         alu_wen_m  <= 1'b0;
         link_wen_m <= 1'b0;
      end else begin
         alu_wen_m  <= ex_ctl.alu_wen;
         link_wen_m <= bru_link_wen;
      end
      // branch link shares the alu target
      target_m  <= ex_ctl.rf_target;
      alu_res_m <= alu_res;
      link_m    <= bru_link;
   end

   ////////////////////
   // memory select
   ////////////////////

   // lsu keeps its own rd since its latency varies
   assign lsu_wen_m = lsu_resp.finish & lsu_resp.wen;

   always_comb begin
      // set if any source claims it
      wb_m.wen = alu_wen_m | link_wen_m | lsu_wen_m;
      if (lsu_resp.finish) begin
         wb_m.rd   = lsu_resp.rd;
         wb_m.data = lsu_resp.rdata;
      end else if (link_wen_m) begin
         wb_m.rd   = target_m;
         wb_m.data = link_m;
      end else begin
         // alu result by default
         wb_m.rd   = target_m;
         wb_m.data = alu_res_m;
      end
   end

   ////////////////////
   // memory to wb
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         wb.wen <= 1'b0;
      end else begin
         wb.wen <= wb_m.wen;
      end
      wb.rd   <= wb_m.rd;
      wb.data <= wb_m.data;
   end

endmodule

/* verilog/ecl_bypass.sv */
`timescale 1ns/1ps

module ecl_bypass (
   input  isa_pkg::reg_idx_t rs_e,
   input  logic              use_other,
   input  isa_pkg::word_t    op_e,
   input  pipe_pkg::wb_t     wb_m,
   input  pipe_pkg::wb_t     wb_w,
   output isa_pkg::word_t    op_fwd
);

   logic fwd_en;
   logic hit_m;
   logic hit_w;

   // operand from pc or immediate never takes a forward,
   // and r0 reads as zero whatever is in flight
   assign fwd_en = ~use_other & (rs_e != '0);

   assign hit_m = fwd_en & wb_m.wen & (wb_m.rd == rs_e);
   assign hit_w = fwd_en & wb_w.wen & (wb_w.rd == rs_e);

   ////////////////////
   // operand mux
   ////////////////////

   // younger result wins
   always_comb begin
      if (hit_m) begin
         op_fwd = wb_m.data;
      end else if (hit_w) begin
         op_fwd = wb_w.data;
      end else begin
         op_fwd = op_e;
      end
   end

   // anything older than write-back was already
   // picked up by the write-through register file read

endmodule

/* verilog/ecl_issue.sv */
`timescale 1ns/1ps
`include "ecl_defs.svh"

module ecl_issue (
   input  logic                clk,
   input  logic                reset,
   input  pipe_pkg::issue_t    issue,
   input  isa_pkg::word_t      rs1_data,
   input  isa_pkg::word_t      rs2_data,
   input  pipe_pkg::bru_resp_t bru_resp,
   input  logic                lsu_finish,
   input  isa_pkg::word_t      opa_fwd,
   input  isa_pkg::word_t      opb_fwd,
   output isa_pkg::reg_idx_t   rs1_idx,
   output isa_pkg::reg_idx_t   rs2_idx,
   output isa_pkg::word_t      opa_e,
   output isa_pkg::word_t      opb_e,
   output isa_pkg::reg_idx_t   rs1_e,
   output isa_pkg::reg_idx_t   rs2_e,
   output logic                a_is_pc_e,
   output logic                b_is_other_e,
   output pipe_pkg::ex_ctl_t   ex_ctl,
   output pipe_pkg::alu_req_t  alu_req,
   output pipe_pkg::lsu_req_t  lsu_req,
   output pipe_pkg::bru_req_t  bru_req,
   output logic                br_taken,
   output isa_pkg::word_t      br_pc,
   output logic                stall_req,
   output isa_pkg::word_t      bru_link,
   output logic                bru_link_wen
);

   // decode to execute payload, no reset
   typedef struct packed {
      isa_pkg::word_t     opa;
      isa_pkg::word_t     opb;
      isa_pkg::reg_idx_t  rs1;
      isa_pkg::reg_idx_t  rs2;
      logic               a_is_pc;
      logic               b_imm;
      logic               double_read;
      logic               rf_wen;
      isa_pkg::reg_idx_t  rf_target;
      isa_pkg::alu_code_t alu_op;
      isa_pkg::lsu_code_t lsu_op;
      isa_pkg::bru_code_t bru_op;
      isa_pkg::word_t     imm;
      isa_pkg::word_t     pc;
      isa_pkg::word_t     br_offs;
   } de_data_t;

   logic                   accept_d;
   logic                   is_alu_d;
   logic                   is_lsu_d;
   logic                   b_imm_d;
   de_data_t               data_d;
   de_data_t               data_e;
   logic                   alu_vld_e;
   logic                   lsu_vld_e;
   logic                   bru_vld_e;
   pipe_pkg::stall_state_t stall_state;
   pipe_pkg::stall_state_t stall_next;

   ////////////////////
   // decode
   ////////////////////

   // taken branch in execute kills decode, stall blocks it
   assign accept_d = issue.valid & ~br_taken & ~stall_req;
   assign is_alu_d = issue.op.unit == isa_pkg::UNIT_ALU;
   assign is_lsu_d = issue.op.unit == isa_pkg::UNIT_LSU;

   assign rs1_idx = issue.op.rd_as_rj ? issue.inst[`ECL_RD_LSB +: `ECL_REG_BITS]
                                      : issue.inst[`ECL_RJ_LSB +: `ECL_REG_BITS];
   assign rs2_idx = issue.op.rd_read ? issue.inst[`ECL_RD_LSB +: `ECL_REG_BITS]
                                     : issue.inst[`ECL_RK_LSB +: `ECL_REG_BITS];

   // immediate b only for alu ops
   assign b_imm_d = issue.op.imm_b & is_alu_d;

   always_comb begin
      data_d.opa         = issue.op.pc_a ? issue.pc : rs1_data;
      data_d.opb         = b_imm_d ? issue.imm : rs2_data;
      data_d.rs1         = rs1_idx;
      data_d.rs2         = rs2_idx;
      data_d.a_is_pc     = issue.op.pc_a;
      data_d.b_imm       = b_imm_d;
      data_d.double_read = issue.op.double_read & is_lsu_d;
      data_d.rf_wen      = issue.rf_wen;
      data_d.rf_target   = issue.rf_target;
      data_d.alu_op      = issue.op.alu_op;
      data_d.lsu_op      = issue.op.lsu_op;
      data_d.bru_op      = issue.op.bru_op;
      data_d.imm         = issue.imm;
      data_d.pc          = issue.pc;
      data_d.br_offs     = issue.br_offs;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         alu_vld_e <= 1'b0;
         lsu_vld_e <= 1'b0;
         bru_vld_e <= 1'b0;
      end else begin
         alu_vld_e <= accept_d & is_alu_d;
         lsu_vld_e <= accept_d & is_lsu_d;
         bru_vld_e <= accept_d & (issue.op.unit == isa_pkg::UNIT_BRU);
      end
      data_e <= data_d;
   end

   ////////////////////
   // execute
   ////////////////////

   assign opa_e        = data_e.opa;
   assign opb_e        = data_e.opb;
   assign rs1_e        = data_e.rs1;
   assign rs2_e        = data_e.rs2;
   assign a_is_pc_e    = data_e.a_is_pc;
   assign b_is_other_e = data_e.b_imm;

   assign ex_ctl.alu_wen   = alu_vld_e & data_e.rf_wen;
   assign ex_ctl.rf_target = data_e.rf_target;

   assign alu_req.a  = opa_fwd;
   assign alu_req.b  = opb_fwd;
   assign alu_req.op = data_e.alu_op;

   // offset is rk for register+register addressing
   assign lsu_req.valid  = lsu_vld_e;
   assign lsu_req.op     = data_e.lsu_op;
   assign lsu_req.base   = opa_fwd;
   assign lsu_req.offset = data_e.double_read ? opb_fwd : data_e.imm;
   assign lsu_req.wdata  = opb_fwd;
   assign lsu_req.rd     = data_e.rf_target;
   assign lsu_req.wen    = data_e.rf_wen;

   assign bru_req.valid  = bru_vld_e;
   assign bru_req.op     = data_e.bru_op;
   assign bru_req.a      = opa_fwd;
   assign bru_req.b      = opb_fwd;
   assign bru_req.pc     = data_e.pc;
   assign bru_req.offset = data_e.br_offs;

   assign br_taken     = bru_vld_e & bru_resp.taken;
   assign br_pc        = bru_resp.brpc;
   assign bru_link     = bru_resp.link_pc;
   assign bru_link_wen = bru_vld_e & bru_resp.wen;

   ////////////////////
   // lsu stall
   ////////////////////

   // lsu valid   _-______
   // finish      ______-_
   // stall_req   _------_
   always_comb begin
      stall_next = stall_state;
      case (stall_state)
         pipe_pkg::STALL_IDLE: begin
            if (lsu_vld_e & ~lsu_finish) begin
               stall_next = pipe_pkg::STALL_WAIT_LSU;
            end
         end
         pipe_pkg::STALL_WAIT_LSU: begin
            if (lsu_finish) begin
               stall_next = pipe_pkg::STALL_IDLE;
            end
         end
         default: stall_next = pipe_pkg::STALL_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         stall_state <= pipe_pkg::STALL_IDLE;
      end else begin
         stall_state <= stall_next;
      end
   end

   assign stall_req = lsu_vld_e | (stall_state == pipe_pkg::STALL_WAIT_LSU);

endmodule

/* verilog/pipe_pkg.sv */
package pipe_pkg;

   // decode-stage request from the IFU
   typedef struct packed {
      logic              valid;
      isa_pkg::inst_t    inst;
      isa_pkg::word_t    pc;
      isa_pkg::dec_op_t  op;
      logic              rf_wen;
      isa_pkg::reg_idx_t rf_target;
      isa_pkg::word_t    imm;
      isa_pkg::word_t    br_offs;
   } issue_t;

   // execute control carried on to write-back
   typedef struct packed {
      logic              alu_wen;
      isa_pkg::reg_idx_t rf_target;
   } ex_ctl_t;

   ////////////////////
   // unit requests
   ////////////////////

   typedef struct packed {
      isa_pkg::word_t     a;
      isa_pkg::word_t     b;
      isa_pkg::alu_code_t op;
   } alu_req_t;

   typedef struct packed {
      logic               valid;
      isa_pkg::lsu_code_t op;
      isa_pkg::word_t     base;
      isa_pkg::word_t     offset;
      isa_pkg::word_t     wdata;
      isa_pkg::reg_idx_t  rd;
      logic               wen;
   } lsu_req_t;

   typedef struct packed {
      logic               valid;
      isa_pkg::bru_code_t op;
      isa_pkg::word_t     a;
      isa_pkg::word_t     b;
      isa_pkg::word_t     pc;
      isa_pkg::word_t     offset;
   } bru_req_t;

   ////////////////////
   // unit responses
   ////////////////////

   // finish is a one-cycle strobe, rd and wen come back with it
   typedef struct packed {
      logic              finish;
      isa_pkg::word_t    rdata;
      isa_pkg::reg_idx_t rd;
      logic              wen;
   } lsu_resp_t;

   typedef struct packed {
      logic           taken;
      isa_pkg::word_t brpc;
      isa_pkg::word_t link_pc;
      logic           wen;
   } bru_resp_t;

   // register file write port, also a forwarding source
   typedef struct packed {
      logic              wen;
      isa_pkg::reg_idx_t rd;
      isa_pkg::word_t    data;
   } wb_t;

   typedef enum logic {
      STALL_IDLE     = 1'b0,
      STALL_WAIT_LSU = 1'b1
   } stall_state_t;

endpackage

/* verilog/isa_pkg.sv */
`include "ecl_defs.svh"

package isa_pkg;

   // plain words and register numbers
   typedef logic [`ECL_GRLEN-1:0]    word_t;
   typedef logic [`ECL_REG_BITS-1:0] reg_idx_t;
   typedef logic [`ECL_INST_BITS-1:0] inst_t;

   // unit operation codes, opaque to the control unit
   typedef logic [`ECL_ALU_CODE_BITS-1:0] alu_code_t;
   typedef logic [`ECL_LSU_CODE_BITS-1:0] lsu_code_t;
   typedef logic [`ECL_BRU_CODE_BITS-1:0] bru_code_t;

   // dispatch target of a decoded instruction
   typedef enum logic [1:0] {
      UNIT_ALU = 2'd0,
      UNIT_LSU = 2'd1,
      UNIT_BRU = 2'd2
   } unit_t;

   ////////////////////
   // decoded op
   ////////////////////

   typedef struct packed {
      unit_t     unit;
      alu_code_t alu_op;
      lsu_code_t lsu_op;
      bru_code_t bru_op;
      // b from the immediate
      logic      imm_b;
      // a from the pc
      logic      pc_a;
      // rs1 reads rd instead of rj
      logic      rd_as_rj;
      // rs2 reads rd instead of rk, e.g. store data
      logic      rd_read;
      // register + register address
      logic      double_read;
   } dec_op_t;

endpackage

/* verilog/ecl_defs.svh */
`ifndef ECL_DEFS_SVH
`define ECL_DEFS_SVH

////////////////////
// datapath widths
////////////////////

`define ECL_GRLEN          32
`define ECL_REG_BITS       5
`define ECL_INST_BITS      32

// operation codes handed through to the units
`define ECL_ALU_CODE_BITS  4
`define ECL_LSU_CODE_BITS  4
`define ECL_BRU_CODE_BITS  4

////////////////////
// instruction fields
////////////////////

// lsb of each register field in the instruction word
`define ECL_RD_LSB         0
`define ECL_RJ_LSB         5
`define ECL_RK_LSB         10

`endif
